// ==== common/pi_pkg.sv ====
`default_nettype none

package pi_pkg;

  // ******************************
  // code fields
  // ******************************
  localparam int PI_CODE_W = 8;
  localparam int PI_FINE_W = 4;

  // coarse phases
  localparam int PI_PHASES = 16;
  localparam int PI_SEL_W  = 4;

  // ******************************
  // phase counter
  // ******************************
  localparam int PI_CNT_W  = 8;
  localparam int PI_PERIOD = 256;
  localparam int PI_HALF   = 128;

  // update fsm
  typedef enum logic {
    UPD_IDLE = 1'b0,
    UPD_PEND = 1'b1
  } pi_upd_state_t;

endpackage

`default_nettype wire

// ==== hdl/pi_phase_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi_phase_gen
  import pi_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  output logic [PI_PHASES-1:0] o_clkph,
  output logic                 o_wrap,
  output logic                 o_clkph0
);

  // counts between adjacent phases
  localparam int PI_STEP = PI_PERIOD / PI_PHASES;

  logic [PI_CNT_W-1:0]  ph_cnt;
  logic [PI_PHASES-1:0] clkph_q;
  logic                 ph0_d1;
  logic                 ph0_d2;

  // phase k is high for the first half period after count 16*k
  function automatic logic ph_level(
    input logic [PI_CNT_W-1:0] cnt,
    input int                  k
  );
    logic [PI_CNT_W-1:0] rel;
    rel = cnt - PI_CNT_W'(k * PI_STEP);
    return (int'(rel) < PI_HALF);
  endfunction

  // ******************************
  // free running phase counter
  // ******************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ph_cnt <= '0;
    end else begin
      ph_cnt <= ph_cnt + 1'b1;
    end
  end

  // last count of the period
  assign o_wrap = (ph_cnt == {PI_CNT_W{1'b1}});

  // ******************************
  // registered phase bus
  // ******************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      clkph_q <= '0;
    end else begin
      for (int k = 0; k < PI_PHASES; k++) begin
        clkph_q[k] <= ph_level(ph_cnt, k);
      end
    end
  end

  assign o_clkph = clkph_q;

  // phase 0 reference, matched to the select and fine stages
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ph0_d1 <= 1'b0;
      ph0_d2 <= 1'b0;
    end else begin
      ph0_d1 <= clkph_q[0];
      ph0_d2 <= ph0_d1;
    end
  end

  assign o_clkph0 = ph0_d2;

endmodule

`default_nettype wire

// ==== hdl/pi_decode_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi_decode_sync
  import pi_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_clk_en,
  input  logic                 i_update,
  input  logic                 i_wrap,
  input  logic [PI_CODE_W-1:0] i_code,
  output logic [PI_SEL_W-1:0]  o_coarse,
  output logic [PI_FINE_W-1:0] o_fine
);

  pi_upd_state_t        state;
  logic [PI_CODE_W-1:0] pend_code;
  logic [PI_CODE_W-1:0] appl_code;
  logic                 capture;

  // updates only count while the clock enable is up
  assign capture = i_update & i_clk_en;

  // ******************************
  // update fsm
  // ******************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= UPD_IDLE;
      appl_code <= '0;
    end else begin
      case (state)
        UPD_IDLE: begin
          if (capture) begin
            state <= UPD_PEND;
          end
        end
        UPD_PEND: begin
          // an update on the wrap itself stays pending for the following wrap
          if (i_wrap) begin
            appl_code <= pend_code;
            if (!capture) begin
              state <= UPD_IDLE;
            end
          end
        end
        default: begin
          state <= UPD_IDLE;
        end
      endcase
    end
  end

  // newest update overwrites the pending code
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pend_code <= '0;
    end else if (capture) begin
      pend_code <= i_code;
    end
  end

  // ******************************
  // field split
  // ******************************
  // upper nibble picks the phase
  assign o_coarse = appl_code[PI_CODE_W-1 -: PI_SEL_W];

  // lower nibble is the fine step
  assign o_fine = appl_code[PI_FINE_W-1:0];

endmodule

`default_nettype wire

// ==== hdl/pi_phase_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi_phase_sel
  import pi_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic [PI_PHASES-1:0] i_clkph,
  input  logic [PI_SEL_W-1:0]  i_coarse,
  output logic                 o_sel_ph
);

  logic sel_next;

  // ******************************
  // 16 to 1 phase mux
  // ******************************
  // both selection stages folded into one
  always_comb begin
    sel_next = i_clkph[i_coarse];
  end

  // one register per channel
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sel_ph <= 1'b0;
    end else begin
      o_sel_ph <= sel_next;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pi_fine_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi_fine_delay
  import pi_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_sel_ph,
  input  logic                 i_pien,
  input  logic [PI_FINE_W-1:0] i_fine,
  output logic                 o_clk
);

  logic                 sel_q;
  logic                 rise_det;
  logic                 fall_det;
  logic                 rise_act;
  logic                 fall_act;
  logic [PI_FINE_W-1:0] rise_cnt;
  logic [PI_FINE_W-1:0] fall_cnt;

  // ******************************
  // edge detect
  // ******************************
  // keeps tracking while disabled, so resume waits for a fresh edge
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sel_q <= 1'b0;
    end else begin
      sel_q <= i_sel_ph;
    end
  end

  assign rise_det = i_sel_ph & ~sel_q;
  assign fall_det = ~i_sel_ph & sel_q;

  // ******************************
  // step counters
  // ******************************
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rise_act <= 1'b0;
      fall_act <= 1'b0;
      rise_cnt <= '0;
      fall_cnt <= '0;
      o_clk    <= 1'b0;
    end else if (!i_pien) begin
      rise_act <= 1'b0;
      fall_act <= 1'b0;
      rise_cnt <= '0;
      fall_cnt <= '0;
      o_clk    <= 1'b0;
    end else begin
      // rising edge, fine 0 is a plain register copy
      if (rise_det) begin
        if (i_fine == '0) begin
          o_clk <= 1'b1;
        end else begin
          rise_act <= 1'b1;
          rise_cnt <= PI_FINE_W'(1);
        end
      end else if (rise_act) begin
        // >= so a code change mid count still fires
        if (rise_cnt >= i_fine) begin
          o_clk    <= 1'b1;
          rise_act <= 1'b0;
        end else begin
          rise_cnt <= rise_cnt + 1'b1;
        end
      end

      // falling edge, same delay
      if (fall_det) begin
        if (i_fine == '0) begin
          o_clk <= 1'b0;
        end else begin
          fall_act <= 1'b1;
          fall_cnt <= PI_FINE_W'(1);
        end
      end else if (fall_act) begin
        if (fall_cnt >= i_fine) begin
          o_clk    <= 1'b0;
          fall_act <= 1'b0;
        end else begin
          fall_cnt <= fall_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pi_oddevn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pi_oddevn_top
  import pi_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_clk_en,
  input  logic                 i_pien,
  input  logic                 i_update,
  input  logic [PI_CODE_W-1:0] i_picode_evn,
  input  logic [PI_CODE_W-1:0] i_picode_odd,
  output logic                 o_clkpi_evn,
  output logic                 o_clkpi_odd,
  output logic                 o_clkph0
);

  logic [PI_PHASES-1:0] clkph;
  logic                 wrap;

  logic [PI_SEL_W-1:0]  evn_coarse;
  logic [PI_FINE_W-1:0] evn_fine;
  logic                 evn_sel_ph;

  logic [PI_SEL_W-1:0]  odd_coarse;
  logic [PI_FINE_W-1:0] odd_fine;
  logic                 odd_sel_ph;

  // ******************************
  // shared phase source
  // ******************************
  pi_phase_gen phase_gen (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .o_clkph  (clkph),
    .o_wrap   (wrap),
    .o_clkph0 (o_clkph0)
  );

  // ******************************
  // even channel
  // ******************************
  pi_decode_sync evn_decode_sync (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_clk_en (i_clk_en),
    .i_update (i_update),
    .i_wrap   (wrap),
    .i_code   (i_picode_evn),
    .o_coarse (evn_coarse),
    .o_fine   (evn_fine)
  );

  pi_phase_sel evn_phase_sel (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_clkph  (clkph),
    .i_coarse (evn_coarse),
    .o_sel_ph (evn_sel_ph)
  );

  pi_fine_delay evn_fine_delay (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sel_ph (evn_sel_ph),
    .i_pien   (i_pien),
    .i_fine   (evn_fine),
    .o_clk    (o_clkpi_evn)
  );

  // ******************************
  // odd channel
  // ******************************
  pi_decode_sync odd_decode_sync (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_clk_en (i_clk_en),
    .i_update (i_update),
    .i_wrap   (wrap),
    .i_code   (i_picode_odd),
    .o_coarse (odd_coarse),
    .o_fine   (odd_fine)
  );

  pi_phase_sel odd_phase_sel (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_clkph  (clkph),
    .i_coarse (odd_coarse),
    .o_sel_ph (odd_sel_ph)
  );

  pi_fine_delay odd_fine_delay (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sel_ph (odd_sel_ph),
    .i_pien   (i_pien),
    .i_fine   (odd_fine),
    .o_clk    (o_clkpi_odd)
  );

endmodule

`default_nettype wire

// ==== bench/tb_pi_oddevn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pi_oddevn_top
  import pi_pkg::*;
();

  localparam int HALF_NS      = 20;
  localparam int CLK_NS       = 2 * HALF_NS;
  localparam int PIPE_LAT     = 3;
  localparam int SETTLE_REFS  = 3;
  localparam int EDGE_TIMEOUT = 2 * PI_PERIOD + 16;
  // periods: reset 3, sweep 7x5, random 20x5, gating 15, pien 10
  localparam int TEST_PERIODS = 3 + 7 * 5 + 20 * 5 + 15 + 10;
  localparam int WATCHDOG_NS  = (TEST_PERIODS + 20) * PI_PERIOD * CLK_NS;

  logic                 i_clk;
  logic                 i_arst_n;
  logic                 i_clk_en;
  logic                 i_pien;
  logic                 i_update;
  logic [PI_CODE_W-1:0] i_picode_evn;
  logic [PI_CODE_W-1:0] i_picode_odd;
  logic                 o_clkpi_evn;
  logic                 o_clkpi_odd;
  logic                 o_clkph0;

  // edge monitor state
  int    cyc = 0;
  int    ref_cyc = 0;
  int    ref_n = 0;
  logic  ref_prev = 1'b0;
  int    rise_cyc [2] = '{0, 0};
  int    rise_n [2] = '{0, 0};
  int    fall_n [2] = '{0, 0};
  int    last_off [2] = '{0, 0};
  int    last_high [2] = '{0, 0};
  logic  ch_prev [2] = '{1'b0, 1'b0};
  logic [1:0] ch_now;
  string ch_name [2] = '{"o_clkpi_evn", "o_clkpi_odd"};

  int          errors;
  int          checks;
  logic [15:0] lfsr;

  pi_oddevn_top UUT (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_clk_en     (i_clk_en),
    .i_pien       (i_pien),
    .i_update     (i_update),
    .i_picode_evn (i_picode_evn),
    .i_picode_odd (i_picode_odd),
    .o_clkpi_evn  (o_clkpi_evn),
    .o_clkpi_odd  (o_clkpi_odd),
    .o_clkph0     (o_clkph0)
  );

  always #HALF_NS i_clk = ~i_clk;

  // ******************************
  // edge monitor, on the falling edge
  // ******************************
  always @(negedge i_clk) begin
    cyc = cyc + 1;
    if (o_clkph0 && !ref_prev) begin
      ref_cyc = cyc;
      ref_n = ref_n + 1;
    end
    ref_prev = o_clkph0;
    ch_now = {o_clkpi_odd, o_clkpi_evn};
    for (int ch = 0; ch < 2; ch++) begin
      if (ch_now[ch] && !ch_prev[ch]) begin
        rise_cyc[ch] = cyc;
        last_off[ch] = (cyc - ref_cyc) % PI_PERIOD;
        rise_n[ch] = rise_n[ch] + 1;
      end else if (!ch_now[ch] && ch_prev[ch]) begin
        last_high[ch] = cyc - rise_cyc[ch];
        fall_n[ch] = fall_n[ch] + 1;
      end
      ch_prev[ch] = ch_now[ch];
    end
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_code(output logic [PI_CODE_W-1:0] val);
    val = '0;
    for (int b = 0; b < PI_CODE_W; b++) begin
      val = {val[PI_CODE_W-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // edge lands code cycles after the reference, folded into one period
  function automatic int expected_offset(input logic [PI_CODE_W-1:0] code);
    return int'(code) % PI_PERIOD;
  endfunction

  task automatic check_value(input string name, input int exp, input int act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic wait_ref_rise(input int count);
    int target;
    int waited;
    target = ref_n + count;
    waited = 0;
    while (ref_n < target && waited < count * EDGE_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    if (ref_n < target) begin
      errors++;
      $display("no rising edge on o_clkph0 in %0d cycles", waited);
    end
  endtask

  // one complete pulse per channel, taken after the call
  task automatic measure_pair(input int exp_evn, input int exp_odd);
    int snap [2];
    int off [2];
    int hi_time [2];
    int exp_off [2];
    bit got [2];
    int waited;
    exp_off[0] = exp_evn;
    exp_off[1] = exp_odd;
    for (int ch = 0; ch < 2; ch++) begin
      snap[ch] = rise_n[ch];
      got[ch] = 1'b0;
    end
    waited = 0;
    while (!(got[0] && got[1]) && waited < EDGE_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
      for (int ch = 0; ch < 2; ch++) begin
        if (!got[ch] && rise_n[ch] > snap[ch] && fall_n[ch] == rise_n[ch]) begin
          got[ch] = 1'b1;
          off[ch] = last_off[ch];
          hi_time[ch] = last_high[ch];
        end
      end
    end
    for (int ch = 0; ch < 2; ch++) begin
      if (!got[ch]) begin
        errors++;
        $display("no complete pulse on %s within %0d cycles", ch_name[ch], waited);
      end else begin
        check_value({ch_name[ch], " rise offset"}, exp_off[ch], off[ch]);
        check_value({ch_name[ch], " high time"}, PI_HALF, hi_time[ch]);
      end
    end
  endtask

  task automatic apply_codes(input logic [PI_CODE_W-1:0] evn,
                             input logic [PI_CODE_W-1:0] odd);
    @(posedge i_clk);
    i_picode_evn <= evn;
    i_picode_odd <= odd;
    i_update <= 1'b1;
    @(posedge i_clk);
    i_update <= 1'b0;
  endtask

  task automatic load_and_check(input logic [PI_CODE_W-1:0] evn,
                                input logic [PI_CODE_W-1:0] odd);
    apply_codes(evn, odd);
    wait_ref_rise(SETTLE_REFS);
    measure_pair(expected_offset(evn), expected_offset(odd));
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic reset_check();
    int rel_cyc;
    for (int i = 0; i < 8; i++) begin
      @(negedge i_clk);
      check_value("o_clkph0 in reset", 0, int'(o_clkph0));
      check_value("o_clkpi_evn in reset", 0, int'(o_clkpi_evn));
      check_value("o_clkpi_odd in reset", 0, int'(o_clkpi_odd));
    end
    @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    rel_cyc = cyc;
    @(negedge i_clk);
    check_value("o_clkph0 after reset", 0, int'(o_clkph0));
    check_value("o_clkpi_evn after reset", 0, int'(o_clkpi_evn));
    check_value("o_clkpi_odd after reset", 0, int'(o_clkpi_odd));
    wait_ref_rise(1);
    check_value("o_clkph0 first rise cycle", rel_cyc + PIPE_LAT, ref_cyc);
    measure_pair(0, 0);
  endtask

  task automatic code_sweep();
    logic [PI_CODE_W-1:0] codes [7];
    codes = '{8'd0, 8'd1, 8'd15, 8'd16, 8'd17, 8'd128, 8'd240};
    foreach (codes[i]) begin
      load_and_check(codes[i], codes[i]);
    end
  endtask

  task automatic evn_odd_independent();
    logic [PI_CODE_W-1:0] evn;
    logic [PI_CODE_W-1:0] odd;
    for (int i = 0; i < 20; i++) begin
      rand_code(evn);
      rand_code(odd);
      // last pair lands in the wrapping range
      if (i == 19) begin
        evn = 8'd241 + evn % 8'd15;
      end
      load_and_check(evn, odd);
    end
  endtask

  task automatic update_gating();
    load_and_check(8'd37, 8'd201);
    @(posedge i_clk);
    i_clk_en <= 1'b0;
    apply_codes(8'd90, 8'd12);
    wait_ref_rise(SETTLE_REFS);
    measure_pair(expected_offset(8'd37), expected_offset(8'd201));
    @(posedge i_clk);
    i_clk_en <= 1'b1;
    // both updates early in the same period
    wait_ref_rise(1);
    apply_codes(8'd66, 8'd180);
    repeat (20) @(posedge i_clk);
    apply_codes(8'd145, 8'd7);
    wait_ref_rise(SETTLE_REFS);
    measure_pair(expected_offset(8'd145), expected_offset(8'd7));
  endtask

  task automatic pien_gate();
    int hi_evn;
    int hi_odd;
    load_and_check(8'd200, 8'd55);
    hi_evn = 0;
    hi_odd = 0;
    @(posedge i_clk);
    i_pien <= 1'b0;
    @(posedge i_clk);
    for (int i = 0; i < PI_PERIOD; i++) begin
      @(negedge i_clk);
      hi_evn += int'(o_clkpi_evn);
      hi_odd += int'(o_clkpi_odd);
    end
    check_value("o_clkpi_evn high cycles with pien low", 0, hi_evn);
    check_value("o_clkpi_odd high cycles with pien low", 0, hi_odd);
    @(posedge i_clk);
    i_pien <= 1'b1;
    wait_ref_rise(2);
    measure_pair(expected_offset(8'd200), expected_offset(8'd55));
  endtask

  // ******************************
  // watchdog
  // ******************************
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns before the tests finished", $time);
    $display("test failed");
    $finish;
  end

  initial begin
    i_clk = 1'b0;
    i_arst_n = 1'b0;
    i_clk_en = 1'b1;
    i_pien = 1'b1;
    i_update = 1'b0;
    i_picode_evn = '0;
    i_picode_odd = '0;
    lfsr = 16'd16540;
    errors = 0;
    checks = 0;
    reset_check();
    code_sweep();
    evn_odd_independent();
    update_gating();
    pien_gate();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
common/pi_pkg.sv
hdl/pi_phase_gen.sv
hdl/pi_decode_sync.sv
hdl/pi_phase_sel.sv
hdl/pi_fine_delay.sv
hdl/pi_oddevn_top.sv
bench/tb_pi_oddevn_top.sv

// ==== Makefile ====
# Verilator build for the dual channel phase interpolator

VERILATOR  ?= verilator
TOP        := tb_pi_oddevn_top
RTL_TOP    := pi_oddevn_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
PASS_MSG   := test passed
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
